//--- Bender.yml
package:
  name: state_vec

sources:
  # Shared package first
  - src/state_pkg.sv
  - src/ctxt_fifo.sv
  - src/update_arbiter.sv
  - src/state_update_calc.sv
  - src/state_store.sv
  - src/state_vector_core.sv
  - target: test
    files:
      - test/tb_state_vector_core.sv

//--- src/ctxt_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module ctxt_fifo #(
    parameter int DATA_WID = 1,
    parameter int DEPTH    = 4
) (
    input  wire logic                clk,
    input  wire logic                srst,
    input  wire logic                wr,
    input  wire logic [DATA_WID-1:0] wr_data,
    input  wire logic                rd,
    output logic      [DATA_WID-1:0] rd_data,
    output logic                     rd_vld
);

    // Pointer and occupancy widths, at least one bit each
    localparam int PTR_WID = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WID = $clog2(DEPTH + 1);

    logic [DATA_WID-1:0] mem [DEPTH];
    logic [PTR_WID-1:0]  wr_ptr;
    logic [PTR_WID-1:0]  rd_ptr;
    logic [CNT_WID-1:0]  count;

    // Entry storage
    always_ff @(posedge clk) begin
        if (wr)
            mem[wr_ptr] <= wr_data;
    end

    // Pointers wrap at DEPTH, not at a power of two
    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr)
                wr_ptr <= (wr_ptr == PTR_WID'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd)
                rd_ptr <= (rd_ptr == PTR_WID'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // No overflow or underflow protection
            case ({wr, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // First word fall-through
    assign rd_data = mem[rd_ptr];
    assign rd_vld  = (count != '0);

endmodule : ctxt_fifo

`default_nettype wire

//--- src/state_pkg.sv
`default_nettype none

package state_pkg;

    // ------------------------------------------------------------------
    // State word layout
    // ------------------------------------------------------------------
    // Packet count in the upper bits, byte count below it
    localparam int STATE_WID    = 32;
    localparam int PKT_CNT_WID  = 12;
    localparam int BYTE_CNT_WID = 20;

    // Length field of a count update
    localparam int LEN_WID = 16;

    // ------------------------------------------------------------------
    // Update opcodes
    // ------------------------------------------------------------------
    typedef enum logic [1:0] {
        UPD_NOP   = 2'd0,  // Read only
        UPD_COUNT = 2'd1,  // One packet plus len bytes
        UPD_SET   = 2'd2   // Overwrite whole word
    } update_op_e;

    // ------------------------------------------------------------------
    // Update word, seen as count update or as raw value
    // ------------------------------------------------------------------
    typedef union packed {
        struct packed {
            logic [STATE_WID-LEN_WID-1:0] rsvd;
            logic [LEN_WID-1:0]           len;
        } count;
        logic [STATE_WID-1:0] raw;
    } update_word_u;

endpackage : state_pkg

`default_nettype wire

//--- src/state_store.sv
`timescale 1ns/1ns
`default_nettype none

module state_store
    import state_pkg::*;
#(
    parameter int ID_WID = 6
) (
    input  wire logic                 clk,
    input  wire logic                 srst,
    output logic                      init_done,

    // Read port, data one cycle after request
    input  wire logic                 rd_req,
    input  wire logic [ID_WID-1:0]    rd_id,
    output logic                      rd_ack,
    output logic      [STATE_WID-1:0] rd_data,

    // Write port
    input  wire logic                 wr_en,
    input  wire logic [ID_WID-1:0]    wr_id,
    input  wire logic [STATE_WID-1:0] wr_data
);

    localparam int DEPTH = 2**ID_WID;

    logic [STATE_WID-1:0] mem [DEPTH];

    logic [ID_WID-1:0]    sweep_id;
    logic                 mem_we;
    logic [ID_WID-1:0]    mem_addr;
    logic [STATE_WID-1:0] mem_din;

    // ------------------------------------------------------------------
    // Clear sweep after reset
    // ------------------------------------------------------------------
    // One entry per cycle, init_done after the last one
    always_ff @(posedge clk) begin
        if (srst) begin
            sweep_id  <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            sweep_id <= sweep_id + 1'b1;
            if (&sweep_id)
                init_done <= 1'b1;
        end
    end

    // Sweep owns the write port until init is done
    assign mem_we   = !init_done || wr_en;
    assign mem_addr = init_done ? wr_id   : sweep_id;
    assign mem_din  = init_done ? wr_data : '0;

    always_ff @(posedge clk) begin
        if (mem_we)
            mem[mem_addr] <= mem_din;
    end

    // ------------------------------------------------------------------
    // Registered read
    // ------------------------------------------------------------------
    // Write-first on an address collision
    always_ff @(posedge clk) begin
        if (wr_en && init_done && (wr_id == rd_id))
            rd_data <= wr_data;
        else
            rd_data <= mem[rd_id];
    end

    always_ff @(posedge clk) begin
        if (srst)
            rd_ack <= 1'b0;
        else
            rd_ack <= rd_req;
    end

endmodule : state_store

`default_nettype wire

//--- src/state_update_calc.sv
`timescale 1ns/1ns
`default_nettype none

module state_update_calc
    import state_pkg::*;
(
    input  wire logic                 en,
    input  wire update_op_e           op,
    input  wire logic                 init,
    input  wire update_word_u         update,
    input  wire logic [STATE_WID-1:0] prev_state,
    output logic      [STATE_WID-1:0] next_state,
    output logic      [STATE_WID-1:0] return_state
);

    logic [STATE_WID-1:0]    base;
    logic [PKT_CNT_WID-1:0]  pkt_cnt;
    logic [BYTE_CNT_WID-1:0] byte_cnt;
    logic [PKT_CNT_WID-1:0]  pkt_cnt_inc;
    logic [BYTE_CNT_WID:0]   byte_sum;
    logic [BYTE_CNT_WID-1:0] byte_cnt_inc;

    // Init starts from a zero state
    assign base = init ? '0 : prev_state;

    // Field split
    assign pkt_cnt  = base[STATE_WID-1 -: PKT_CNT_WID];
    assign byte_cnt = base[BYTE_CNT_WID-1:0];

    // ------------------------------------------------------------------
    // Saturating counters
    // ------------------------------------------------------------------
    assign pkt_cnt_inc = (&pkt_cnt) ? pkt_cnt : pkt_cnt + 1'b1;

    // Extra carry bit flags byte overflow
    assign byte_sum     = {1'b0, byte_cnt} + (BYTE_CNT_WID + 1)'(update.count.len);
    assign byte_cnt_inc = byte_sum[BYTE_CNT_WID] ? '1 : byte_sum[BYTE_CNT_WID-1:0];

    // ------------------------------------------------------------------
    // Next state select
    // ------------------------------------------------------------------
    always_comb begin
        next_state = base;
        if (en) begin
            case (op)
                UPD_COUNT: next_state = {pkt_cnt_inc, byte_cnt_inc};
                UPD_SET:   next_state = update.raw;
                default:   next_state = base;
            endcase
        end
    end

    // Requester sees the value before its own update
    assign return_state = base;

endmodule : state_update_calc

`default_nettype wire

//--- src/state_vector_core.sv
`timescale 1ns/1ns
`default_nettype none

module state_vector_core
    import state_pkg::*;
#(
    parameter int ID_WID           = 6,
    parameter int NUM_TRANSACTIONS = 4
) (
    input  wire logic              clk,
    input  wire logic              srst,
    input  wire logic              en,
    output logic                   init_done,

    // Datapath requester
    input  wire logic              upd_req,
    output logic                   upd_rdy,
    input  wire logic [ID_WID-1:0] upd_id,
    input  wire update_op_e        upd_op,
    input  wire logic              upd_init,
    input  wire update_word_u      upd_update,
    output logic                   upd_ack,
    output logic [STATE_WID-1:0]   upd_state,

    // Control plane requester
    input  wire logic              ctrl_req,
    output logic                   ctrl_rdy,
    input  wire logic [ID_WID-1:0] ctrl_id,
    input  wire update_op_e        ctrl_op,
    input  wire logic              ctrl_init,
    input  wire update_word_u      ctrl_update,
    output logic                   ctrl_ack,
    output logic [STATE_WID-1:0]   ctrl_state
);

    // id, op, init, update, back-to-back flag
    localparam int CTXT_WID = ID_WID + $bits(update_op_e) + 1 + STATE_WID + 1;

    // Granted request
    logic                 arb_req;
    logic [ID_WID-1:0]    arb_id;
    update_op_e           arb_op;
    logic                 arb_init;
    update_word_u         arb_update;

    // Context of the transaction being completed
    logic [CTXT_WID-1:0]  ctxt_in;
    logic [CTXT_WID-1:0]  ctxt_out;
    logic                 ctxt_vld;
    logic [ID_WID-1:0]    ctxt_id;
    logic [1:0]           ctxt_op;
    logic                 ctxt_init;
    update_word_u         ctxt_update;
    logic                 ctxt_b2b;

    logic [ID_WID-1:0]    last_id;
    logic                 back_to_back;

    // Store and calc
    logic                 rd_ack;
    logic [STATE_WID-1:0] rd_data;
    logic                 wr_en;
    logic [ID_WID-1:0]    wr_id;
    logic [STATE_WID-1:0] wr_data;
    logic [STATE_WID-1:0] prev_state;
    logic [STATE_WID-1:0] next_state;
    logic [STATE_WID-1:0] return_state;
    logic                 rsp_go;
    logic                 resp_ack;
    logic [STATE_WID-1:0] resp_state;

    // ------------------------------------------------------------------
    // Requester arbitration
    // ------------------------------------------------------------------
    update_arbiter #(
        .ID_WID           ( ID_WID ),
        .NUM_TRANSACTIONS ( NUM_TRANSACTIONS )
    ) i_update_arbiter (
        .clk         ( clk ),
        .srst        ( srst ),
        .init_done   ( init_done ),
        .upd_req     ( upd_req ),
        .upd_rdy     ( upd_rdy ),
        .upd_id      ( upd_id ),
        .upd_op      ( upd_op ),
        .upd_init    ( upd_init ),
        .upd_update  ( upd_update ),
        .upd_ack     ( upd_ack ),
        .upd_state   ( upd_state ),
        .ctrl_req    ( ctrl_req ),
        .ctrl_rdy    ( ctrl_rdy ),
        .ctrl_id     ( ctrl_id ),
        .ctrl_op     ( ctrl_op ),
        .ctrl_init   ( ctrl_init ),
        .ctrl_update ( ctrl_update ),
        .ctrl_ack    ( ctrl_ack ),
        .ctrl_state  ( ctrl_state ),
        .arb_req     ( arb_req ),
        .arb_id      ( arb_id ),
        .arb_op      ( arb_op ),
        .arb_init    ( arb_init ),
        .arb_update  ( arb_update ),
        .resp_ack    ( resp_ack ),
        .resp_state  ( resp_state )
    );

    // ------------------------------------------------------------------
    // Read-modify-write context
    // ------------------------------------------------------------------
    // Same ID as the previous accepted transfer
    always_ff @(posedge clk) begin
        if (arb_req)
            last_id <= arb_id;
    end
    assign back_to_back = (arb_id == last_id);

    assign ctxt_in = {arb_id, arb_op, arb_init, arb_update, back_to_back};

    ctxt_fifo #(
        .DATA_WID ( CTXT_WID ),
        .DEPTH    ( NUM_TRANSACTIONS )
    ) i_ctxt_fifo_rmw (
        .clk     ( clk ),
        .srst    ( srst ),
        .wr      ( arb_req ),
        .wr_data ( ctxt_in ),
        .rd      ( rd_ack ),
        .rd_data ( ctxt_out ),
        .rd_vld  ( ctxt_vld )
    );

    assign {ctxt_id, ctxt_op, ctxt_init, ctxt_update, ctxt_b2b} = ctxt_out;

    // ------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------
    state_store #(
        .ID_WID ( ID_WID )
    ) i_state_store (
        .clk       ( clk ),
        .srst      ( srst ),
        .init_done ( init_done ),
        .rd_req    ( arb_req ),
        .rd_id     ( arb_id ),
        .rd_ack    ( rd_ack ),
        .rd_data   ( rd_data ),
        .wr_en     ( wr_en ),
        .wr_id     ( wr_id ),
        .wr_data   ( wr_data )
    );

    // Pending write holds the newest state; the read missed it
    assign prev_state = (ctxt_b2b && wr_en) ? wr_data : rd_data;

    state_update_calc i_state_update_calc (
        .en           ( en ),
        .op           ( update_op_e'(ctxt_op) ),
        .init         ( ctxt_init ),
        .update       ( ctxt_update ),
        .prev_state   ( prev_state ),
        .next_state   ( next_state ),
        .return_state ( return_state )
    );

    // ------------------------------------------------------------------
    // Write-back and response
    // ------------------------------------------------------------------
    assign rsp_go = rd_ack && ctxt_vld;

    always_ff @(posedge clk) begin
        if (srst) begin
            wr_en    <= 1'b0;
            resp_ack <= 1'b0;
        end else begin
            wr_en    <= rsp_go;
            resp_ack <= rsp_go;
        end
    end

    // Payload, qualified by the strobes above
    always_ff @(posedge clk) begin
        if (rsp_go) begin
            wr_id      <= ctxt_id;
            wr_data    <= next_state;
            resp_state <= return_state;
        end
    end

endmodule : state_vector_core

`default_nettype wire

//--- src/update_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module update_arbiter
    import state_pkg::*;
#(
    parameter int ID_WID           = 6,
    parameter int NUM_TRANSACTIONS = 4
) (
    input  wire logic                 clk,
    input  wire logic                 srst,
    input  wire logic                 init_done,

    // Datapath requester
    input  wire logic                 upd_req,
    output logic                      upd_rdy,
    input  wire logic [ID_WID-1:0]    upd_id,
    input  wire update_op_e           upd_op,
    input  wire logic                 upd_init,
    input  wire update_word_u         upd_update,
    output logic                      upd_ack,
    output logic [STATE_WID-1:0]      upd_state,

    // Control plane requester
    input  wire logic                 ctrl_req,
    output logic                      ctrl_rdy,
    input  wire logic [ID_WID-1:0]    ctrl_id,
    input  wire update_op_e           ctrl_op,
    input  wire logic                 ctrl_init,
    input  wire update_word_u         ctrl_update,
    output logic                      ctrl_ack,
    output logic [STATE_WID-1:0]      ctrl_state,

    // Granted request toward the core
    output logic                      arb_req,
    output logic [ID_WID-1:0]         arb_id,
    output update_op_e                arb_op,
    output logic                      arb_init,
    output update_word_u              arb_update,

    // Response from the core
    input  wire logic                 resp_ack,
    input  wire logic [STATE_WID-1:0] resp_state
);

    logic src_ctrl;
    logic src_vld;

    // ------------------------------------------------------------------
    // Strict priority grant
    // ------------------------------------------------------------------
    // Datapath only waits for init; control also yields to datapath
    assign upd_rdy  = init_done;
    assign ctrl_rdy = init_done && !upd_req;

    assign arb_req    = (upd_req && upd_rdy) || (ctrl_req && ctrl_rdy);
    assign arb_id     = upd_req ? upd_id     : ctrl_id;
    assign arb_op     = upd_req ? upd_op     : ctrl_op;
    assign arb_init   = upd_req ? upd_init   : ctrl_init;
    assign arb_update = upd_req ? upd_update : ctrl_update;

    // ------------------------------------------------------------------
    // Response routing
    // ------------------------------------------------------------------
    // One bit per grant, set when control won
    ctxt_fifo #(
        .DATA_WID ( 1 ),
        .DEPTH    ( NUM_TRANSACTIONS )
    ) i_ctxt_fifo_src (
        .clk     ( clk ),
        .srst    ( srst ),
        .wr      ( arb_req ),
        .wr_data ( !upd_req ),
        .rd      ( resp_ack ),
        .rd_data ( src_ctrl ),
        .rd_vld  ( src_vld )
    );

    // Responses return in grant order
    assign upd_ack    = resp_ack && src_vld && !src_ctrl;
    assign ctrl_ack   = resp_ack && src_vld &&  src_ctrl;
    assign upd_state  = resp_state;
    assign ctrl_state = resp_state;

endmodule : update_arbiter

`default_nettype wire

//--- state_vec.f
src/state_pkg.sv
src/ctxt_fifo.sv
src/update_arbiter.sv
src/state_update_calc.sv
src/state_store.sv
src/state_vector_core.sv
test/tb_state_vector_core.sv

//--- test/tb_state_vector_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_state_vector_core
    import state_pkg::*;
();

    localparam int ID_WID     = 6;
    localparam int NUM_IDS    = 2**ID_WID;
    // Reset 16 + sweep 64 + about 200 cycles of traffic, with wide margin
    localparam int MAX_CYCLES = 4000;
    localparam logic [BYTE_CNT_WID:0] BYTE_MAX = {1'b0, {BYTE_CNT_WID{1'b1}}};

    logic                 clk = 1'b0;
    logic                 srst;
    logic                 en;
    logic                 init_done;
    logic                 upd_req;
    logic                 upd_rdy;
    logic [ID_WID-1:0]    upd_id;
    update_op_e           upd_op;
    logic                 upd_init;
    update_word_u         upd_update;
    logic                 upd_ack;
    logic [STATE_WID-1:0] upd_state;
    logic                 ctrl_req;
    logic                 ctrl_rdy;
    logic [ID_WID-1:0]    ctrl_id;
    update_op_e           ctrl_op;
    logic                 ctrl_init;
    update_word_u         ctrl_update;
    logic                 ctrl_ack;
    logic [STATE_WID-1:0] ctrl_state;

    // Reference table and expected responses per source
    logic [STATE_WID-1:0] model [NUM_IDS];
    logic [STATE_WID-1:0] exp_upd_state [$];
    int                   exp_upd_due [$];
    logic [STATE_WID-1:0] exp_ctrl_state [$];
    int                   exp_ctrl_due [$];

    int     cyc;
    int     ncyc;
    int     errors;
    int     checks;
    integer seed;

    state_vector_core #(
        .ID_WID           ( ID_WID ),
        .NUM_TRANSACTIONS ( 4 )
    ) uut (
        .clk         ( clk ),
        .srst        ( srst ),
        .en          ( en ),
        .init_done   ( init_done ),
        .upd_req     ( upd_req ),
        .upd_rdy     ( upd_rdy ),
        .upd_id      ( upd_id ),
        .upd_op      ( upd_op ),
        .upd_init    ( upd_init ),
        .upd_update  ( upd_update ),
        .upd_ack     ( upd_ack ),
        .upd_state   ( upd_state ),
        .ctrl_req    ( ctrl_req ),
        .ctrl_rdy    ( ctrl_rdy ),
        .ctrl_id     ( ctrl_id ),
        .ctrl_op     ( ctrl_op ),
        .ctrl_init   ( ctrl_init ),
        .ctrl_update ( ctrl_update ),
        .ctrl_ack    ( ctrl_ack ),
        .ctrl_state  ( ctrl_state )
    );

    always #5 clk = ~clk;

    // ------------------------------------------------------------------
    // Reference model of one update
    // ------------------------------------------------------------------
    function automatic logic [STATE_WID-1:0] model_next(
        input logic [STATE_WID-1:0] base,
        input update_op_e           op,
        input logic                 en_now,
        input update_word_u         word
    );
        logic [PKT_CNT_WID-1:0] pkt;
        logic [BYTE_CNT_WID:0]  bytes;
        pkt   = base[STATE_WID-1:BYTE_CNT_WID];
        bytes = base[BYTE_CNT_WID-1:0];
        if (!en_now || op == UPD_NOP)
            return base;
        if (op == UPD_SET)
            return word.raw;
        // Count: both fields stop at all ones
        if (pkt != {PKT_CNT_WID{1'b1}})
            pkt = pkt + 1;
        bytes = bytes + word.count.len;
        if (bytes > BYTE_MAX)
            bytes = BYTE_MAX;
        return {pkt, bytes[BYTE_CNT_WID-1:0]};
    endfunction

    // Model one accepted transfer, response due two cycles later
    task automatic record(input bit src, input logic [ID_WID-1:0] id, input update_op_e op,
                          input logic init, input update_word_u word);
        logic [STATE_WID-1:0] base;
        base      = init ? '0 : model[id];
        model[id] = model_next(base, op, en, word);
        if (src) begin
            exp_ctrl_state.push_back(base);
            exp_ctrl_due.push_back(ncyc + 2);
        end else begin
            exp_upd_state.push_back(base);
            exp_upd_due.push_back(ncyc + 2);
        end
    endtask

    // Match one port's ack against the oldest expected response
    task automatic check_resp(input bit src, input logic ack, input logic [STATE_WID-1:0] got);
        int                   n;
        int                   due;
        logic [STATE_WID-1:0] want;
        n = src ? exp_ctrl_state.size() : exp_upd_state.size();
        if (n == 0) begin
            if (ack) begin
                errors++;
                $display("Unexpected ack on the %s port at cycle %0d",
                         src ? "ctrl" : "upd", ncyc);
            end
        end else begin
            due  = src ? exp_ctrl_due[0] : exp_upd_due[0];
            want = src ? exp_ctrl_state[0] : exp_upd_state[0];
            if (ack || due <= ncyc) begin
                if (src) begin
                    void'(exp_ctrl_state.pop_front());
                    void'(exp_ctrl_due.pop_front());
                end else begin
                    void'(exp_upd_state.pop_front());
                    void'(exp_upd_due.pop_front());
                end
                checks++;
                if (!ack) begin
                    errors++;
                    $display("Missing ack on the %s port at cycle %0d",
                             src ? "ctrl" : "upd", ncyc);
                end else if (due != ncyc) begin
                    errors++;
                    $display("Ack on the %s port at cycle %0d, two cycles after accept expected",
                             src ? "ctrl" : "upd", ncyc);
                end
                if (ack && got !== want) begin
                    errors++;
                    $display("** Error: %s = 0x%08h, expected 0x%08h",
                             src ? "ctrl_state" : "upd_state", got, want);
                end
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Monitor, mid-cycle where everything is settled
    // ------------------------------------------------------------------
    always @(negedge clk) begin
        ncyc = ncyc + 1;
        if (srst) begin
            // Strobes must be a clean zero while reset is held
            if (upd_ack !== 1'b0 || ctrl_ack !== 1'b0) begin
                errors++;
                $display("Ack seen during reset at cycle %0d", ncyc);
            end
            if (upd_rdy !== 1'b0 || ctrl_rdy !== 1'b0) begin
                errors++;
                $display("Ready raised during reset at cycle %0d", ncyc);
            end
        end else begin
            if (!init_done && (upd_rdy || ctrl_rdy)) begin
                errors++;
                $display("Ready raised before init_done at cycle %0d", ncyc);
            end
            if (upd_req && ctrl_rdy) begin
                errors++;
                $display("ctrl_rdy high while upd_req is high at cycle %0d", ncyc);
            end
            check_resp(1'b0, upd_ack, upd_state);
            check_resp(1'b1, ctrl_ack, ctrl_state);
            if (upd_req && upd_rdy)
                record(1'b0, upd_id, upd_op, upd_init, upd_update);
            if (ctrl_req && ctrl_rdy)
                record(1'b1, ctrl_id, ctrl_op, ctrl_init, ctrl_update);
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, checks: %0d, errors: %0d",
                     cyc, checks, errors);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Drivers
    // ------------------------------------------------------------------
    // Hold the request until a cycle with rdy high has passed
    task automatic send(input bit src, input logic [ID_WID-1:0] id, input update_op_e op,
                        input logic init, input logic [STATE_WID-1:0] word);
        bit taken;
        taken = 1'b0;
        if (src) begin
            ctrl_req        = 1'b1;
            ctrl_id         = id;
            ctrl_op         = op;
            ctrl_init       = init;
            ctrl_update.raw = word;
        end else begin
            upd_req        = 1'b1;
            upd_id         = id;
            upd_op         = op;
            upd_init       = init;
            upd_update.raw = word;
        end
        while (!taken) begin
            @(negedge clk);
            taken = src ? ctrl_rdy : upd_rdy;
            @(posedge clk);
            #1;
        end
        if (src)
            ctrl_req = 1'b0;
        else
            upd_req = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_upd_state.size() != 0 || exp_ctrl_state.size() != 0)
            @(posedge clk);
        @(posedge clk);
        #1;
    endtask

    // ------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------
    task automatic read_after_sweep();
        int n;
        n = 0;
        while (!init_done) begin
            @(posedge clk);
            n++;
            #1;
        end
        checks++;
        if (n != NUM_IDS) begin
            errors++;
            $display("** Error: init_done cycles = 0x%0h, expected 0x%0h", n, NUM_IDS);
        end
        for (int i = 0; i < 8; i++)
            send(1'b1, ID_WID'(i * 7), UPD_NOP, 1'b0, '0);
        wait_idle();
    endtask

    task automatic accumulate_counts();
        logic [ID_WID-1:0] ids [12];
        for (int i = 0; i < 12; i++) begin
            ids[i] = ID_WID'($random(seed));
            send(1'b0, ids[i], UPD_COUNT, 1'b0, {16'h0, 16'($random(seed))});
        end
        // Large lengths drive the byte field into saturation
        for (int i = 0; i < 20; i++)
            send(1'b0, 6'd40, UPD_COUNT, 1'b0, 32'h0000_ffff);
        for (int i = 0; i < 12; i++)
            send(1'b0, ids[i], UPD_NOP, 1'b0, '0);
        send(1'b0, 6'd40, UPD_NOP, 1'b0, '0);
        wait_idle();
    endtask

    task automatic forward_same_id();
        for (int i = 1; i <= 6; i++)
            send(1'b0, 6'd5, UPD_COUNT, 1'b0, 32'(i * 3));
        // Same ID split by one other ID
        send(1'b0, 6'd5, UPD_COUNT, 1'b0, 32'h10);
        send(1'b0, 6'd6, UPD_COUNT, 1'b0, 32'h20);
        send(1'b0, 6'd5, UPD_COUNT, 1'b0, 32'h30);
        send(1'b0, 6'd6, UPD_COUNT, 1'b0, 32'h40);
        send(1'b0, 6'd6, UPD_NOP, 1'b0, '0);
        send(1'b0, 6'd5, UPD_NOP, 1'b0, '0);
        wait_idle();
    endtask

    task automatic overwrite_and_init();
        send(1'b1, 6'd9, UPD_SET, 1'b0, 32'h0123_4567);
        send(1'b1, 6'd9, UPD_NOP, 1'b0, '0);
        send(1'b0, 6'd9, UPD_COUNT, 1'b1, 32'd100);
        send(1'b1, 6'd9, UPD_NOP, 1'b0, '0);
        wait_idle();
    endtask

    task automatic contend_sources();
        fork
            begin
                for (int i = 0; i < 6; i++) begin
                    send(1'b0, ID_WID'(20 + i % 2), UPD_COUNT, 1'b0, 32'(i + 1));
                    // One idle cycle lets the control plane in
                    if (i == 2) begin
                        @(posedge clk);
                        #1;
                    end
                end
            end
            begin
                send(1'b1, 6'd20, UPD_SET, 1'b0, 32'h0abc_0000);
                send(1'b1, 6'd21, UPD_NOP, 1'b0, '0);
                send(1'b1, 6'd20, UPD_NOP, 1'b0, '0);
                send(1'b1, 6'd22, UPD_SET, 1'b0, 32'h5555_aaaa);
            end
        join
        send(1'b0, 6'd22, UPD_NOP, 1'b0, '0);
        wait_idle();
    endtask

    task automatic freeze_counters();
        en = 1'b0;
        send(1'b0, 6'd5, UPD_COUNT, 1'b0, 32'h77);
        send(1'b1, 6'd9, UPD_SET, 1'b0, 32'hdead_beef);
        send(1'b0, 6'd9, UPD_COUNT, 1'b0, 32'h1);
        wait_idle();
        en = 1'b1;
        send(1'b1, 6'd5, UPD_NOP, 1'b0, '0);
        send(1'b1, 6'd9, UPD_NOP, 1'b0, '0);
        wait_idle();
    endtask

    initial begin
        seed        = 11209;
        cyc         = 0;
        ncyc        = 0;
        errors      = 0;
        checks      = 0;
        srst        = 1'b1;
        en          = 1'b1;
        upd_req     = 1'b0;
        upd_id      = '0;
        upd_op      = UPD_NOP;
        upd_init    = 1'b0;
        upd_update  = '0;
        ctrl_req    = 1'b0;
        ctrl_id     = '0;
        ctrl_op     = UPD_NOP;
        ctrl_init   = 1'b0;
        ctrl_update = '0;
        // Table reads as zero once the sweep is done
        for (int i = 0; i < NUM_IDS; i++)
            model[i] = '0;
        repeat (16) @(posedge clk);
        #1;
        srst = 1'b0;

        read_after_sweep();
        accumulate_counts();
        forward_same_id();
        overwrite_and_init();
        contend_sources();
        freeze_counters();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule : tb_state_vector_core

`default_nettype wire
